// File: all.f
lsu_pkg.sv
exu_pkg.sv
data_ram.sv
exu_lsu.sv
exu_alu.sv
exu_next_pc.sv
exu_ctrl.sv
exu_top.sv
tb_clock.sv
exu_sva.sv
exu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= exu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: exu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exu_tb;

    // expected response of one operation
    typedef struct packed {
        logic        chk_rd;
        logic [31:0] rd;
        logic [31:0] npc;
        logic        halt;
        logic [31:0] code;
    } expect_t;

    localparam int RAM_BYTES = lsu_pkg::RAM_WORDS * 4;
    localparam int MAX_WAIT  = 20;

    logic             clk;
    logic             reset;
    logic             valid;
    exu_pkg::exu_op_u opt;
    logic [31:0]      rs1_d;
    logic [31:0]      rs2_d;
    logic [31:0]      imm;
    logic [31:0]      pc;
    logic [31:0]      csr_rdata;
    logic             ready;
    logic [31:0]      rd_d;
    logic [31:0]      dnpc;
    logic             halt;
    logic [31:0]      exit_code;

    integer           seed;
    logic [7:0]       shadow [RAM_BYTES];
    expect_t          exp_q [$];
    string            name_q [$];

    tb_clock clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    exu_top exu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .opt       (opt),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .csr_rdata (csr_rdata),
        .ready     (ready),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .exit_code (exit_code)
    );

    // ------------------------------
    // stimulus helpers
    // ------------------------------

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic logic [31:0] random_pc();
        random_pc = next_random() & 32'hffff_fffc;
    endfunction

    function automatic lsu_pkg::mem_size_e random_size(logic [1:0] bits);
        return (bits == 2'd0) ? lsu_pkg::MEM_WORD : lsu_pkg::mem_size_e'(bits);
    endfunction

    function automatic exu_pkg::exu_op_u main_word(
        logic modf, logic inv, logic ld, lsu_pkg::mem_size_e size,
        exu_pkg::pc_sel_e psel, exu_pkg::alu_fn_e fn, exu_pkg::src_sel_e src);
        exu_pkg::op_main_t m;
        exu_pkg::exu_op_u  u;
        m          = '0;
        m.modifier = modf;
        m.invert   = inv;
        m.load     = ld;
        m.mem_size = size;
        m.pc_sel   = psel;
        m.alu_fn   = fn;
        m.src_sel  = src;
        u.main     = m;
        return u;
    endfunction

    // spare bits overlay load, size and pc_sel of the main view
    function automatic exu_pkg::exu_op_u sys_word(exu_pkg::sys_fn_e fn, logic [13:0] junk);
        exu_pkg::op_sys_t s;
        exu_pkg::exu_op_u u;
        s.sys    = 1'b1;
        s.sys_fn = fn;
        s.spare  = junk;
        u.sys    = s;
        return u;
    endfunction

    function automatic expect_t make_expect(logic chk, logic [31:0] rd, logic [31:0] npc,
                                            logic hlt, logic [31:0] code);
        expect_t e;
        e.chk_rd = chk;
        e.rd     = rd;
        e.npc    = npc;
        e.halt   = hlt;
        e.code   = code;
        return e;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic [31:0] alu_model(
        exu_pkg::src_sel_e src, exu_pkg::alu_fn_e fn, logic modf,
        logic [31:0] rs1, logic [31:0] rs2, logic [31:0] im, logic [31:0] p);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        lt;
        case (src)
            exu_pkg::SRC_IMM_ZERO: begin
                a = im;
                b = 32'd0;
            end
            exu_pkg::SRC_PC_IMM: begin
                a = p;
                b = im;
            end
            exu_pkg::SRC_RS1_RS2: begin
                a = rs1;
                b = rs2;
            end
            default: begin
                a = rs1;
                b = im;
            end
        endcase
        sh = b[4:0];
        lt = modf ? ($signed(a) < $signed(b)) : (a < b);
        case (fn)
            exu_pkg::ALU_ADD: return modf ? a - b : a + b;
            exu_pkg::ALU_SLL: return a << sh;
            exu_pkg::ALU_SLT: return {31'd0, lt};
            exu_pkg::ALU_XOR: return a ^ b;
            // fill the vacated top bits with the sign for sra
            exu_pkg::ALU_SRL: return (a >> sh) | ((modf && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
            exu_pkg::ALU_OR:  return a | b;
            exu_pkg::ALU_AND: return a & b;
            default:          return {31'd0, a == b};
        endcase
    endfunction

    function automatic logic [31:0] load_model(lsu_pkg::mem_size_e size, logic sign,
                                               logic [31:0] addr);
        logic [9:0] at;
        logic [7:0] lo;
        logic [7:0] hi;
        at = addr[9:0];
        case (size)
            lsu_pkg::MEM_BYTE: begin
                lo = shadow[at];
                return {{24{sign & lo[7]}}, lo};
            end
            lsu_pkg::MEM_HALF: begin
                lo = shadow[{at[9:1], 1'b0}];
                hi = shadow[{at[9:1], 1'b1}];
                return {{16{sign & hi[7]}}, hi, lo};
            end
            default: begin
                return {shadow[{at[9:2], 2'd3}], shadow[{at[9:2], 2'd2}],
                        shadow[{at[9:2], 2'd1}], shadow[{at[9:2], 2'd0}]};
            end
        endcase
    endfunction

    // low address bits below the access size are dropped
    task automatic shadow_store(lsu_pkg::mem_size_e size, logic [31:0] addr, logic [31:0] data);
        logic [9:0] at;
        at = addr[9:0];
        case (size)
            lsu_pkg::MEM_BYTE: shadow[at] = data[7:0];
            lsu_pkg::MEM_HALF: begin
                shadow[{at[9:1], 1'b0}] = data[7:0];
                shadow[{at[9:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++)
                    shadow[{at[9:2], k[1:0]}] = data[8*k +: 8];
            end
        endcase
    endtask

    // ------------------------------
    // checking
    // ------------------------------

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_result();
        expect_t e;
        string   name;
        e    = exp_q.pop_front();
        name = name_q.pop_front();
        if (e.chk_rd)
            check_value({name, " rd_d"}, e.rd, rd_d);
        check_value({name, " dnpc"}, e.npc, dnpc);
        check_value({name, " halt"}, {31'd0, e.halt}, {31'd0, halt});
        if (e.halt)
            check_value({name, " exit_code"}, e.code, exit_code);
    endtask

    // outputs are registered, so the middle of the ready cycle is safe
    always @(negedge clk) begin
        if (!reset && ready) begin
            if (exp_q.size() == 0) begin
                $display("ready pulsed with no operation in flight");
                fail_run();
            end else begin
                check_result();
            end
        end
    end

    // ------------------------------
    // driving
    // ------------------------------

    task automatic issue_op(string name, exu_pkg::exu_op_u op, logic [31:0] a,
                            logic [31:0] b, logic [31:0] i, logic [31:0] p,
                            logic [31:0] csr, expect_t e);
        @(posedge clk);
        #1;
        valid     = 1'b1;
        opt       = op;
        rs1_d     = a;
        rs2_d     = b;
        imm       = i;
        pc        = p;
        csr_rdata = csr;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (reset !== 1'b0 && cycles < MAX_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            fail_run();
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < MAX_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("no ready pulse for %s within %0d cycles", name_q[0], MAX_WAIT);
            fail_run();
        end
    endtask

    task automatic issue_store(lsu_pkg::mem_size_e size, logic [31:0] addr, logic [31:0] data);
        logic [31:0] a;
        logic [31:0] p;
        a = next_random();
        p = random_pc();
        shadow_store(size, addr, data);
        issue_op("store", main_word(1'b0, 1'b0, 1'b0, size, exu_pkg::PC_SEQ, exu_pkg::ALU_ADD,
                 exu_pkg::SRC_RS1_IMM), a, data, addr - a, p, next_random(),
                 make_expect(1'b1, addr, p + 32'd4, 1'b0, 32'd0));
    endtask

    task automatic issue_load(lsu_pkg::mem_size_e size, logic sign, logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] p;
        a = next_random();
        p = random_pc();
        issue_op("load", main_word(sign, 1'b0, 1'b1, size, exu_pkg::PC_SEQ, exu_pkg::ALU_ADD,
                 exu_pkg::SRC_RS1_IMM), a, next_random(), addr - a, p, next_random(),
                 make_expect(1'b1, load_model(size, sign, addr), p + 32'd4, 1'b0, 32'd0));
    endtask

    // ------------------------------
    // test groups
    // ------------------------------

    task automatic fill_ram();
        logic [7:0] w8;
        for (int w = 0; w < lsu_pkg::RAM_WORDS; w++) begin
            w8 = w[7:0];
            issue_store(lsu_pkg::MEM_WORD, {22'd0, w8, 2'b00},
                        {w8, ~w8, w8 ^ 8'ha5, w8 + 8'd17});
        end
    endtask

    task automatic sweep_ram();
        for (int w = 0; w < lsu_pkg::RAM_WORDS; w++)
            issue_load(lsu_pkg::MEM_WORD, 1'b0, {22'd0, w[7:0], 2'b00});
    endtask

    task automatic run_alu(int count);
        logic [31:0]       r;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       i;
        logic [31:0]       p;
        exu_pkg::src_sel_e src;
        exu_pkg::alu_fn_e  fn;
        logic              modf;
        for (int n = 0; n < count; n++) begin
            r    = next_random();
            a    = next_random();
            b    = next_random();
            i    = next_random();
            p    = random_pc();
            src  = exu_pkg::src_sel_e'(r[1:0]);
            fn   = exu_pkg::alu_fn_e'(r[4:2]);
            // auipc style pairing never carries the modifier
            modf = r[5] && src != exu_pkg::SRC_PC_IMM;
            // equal operands now and then
            if (r[6]) begin
                b = a;
                i = a;
            end
            issue_op("alu", main_word(modf, r[7], 1'b0, lsu_pkg::MEM_NONE, exu_pkg::PC_SEQ,
                     fn, src), a, b, i, p, next_random(),
                     make_expect(1'b1, alu_model(src, fn, modf, a, b, i, p), p + 32'd4,
                                 1'b0, 32'd0));
            if (r[8])
                go_idle();
        end
    endtask

    task automatic run_flow(int count);
        logic [31:0]      r;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      i;
        logic [31:0]      p;
        logic [31:0]      res;
        exu_pkg::alu_fn_e fn;
        for (int n = 0; n < count; n++) begin
            r  = next_random();
            a  = next_random();
            b  = r[5] ? a : next_random();
            i  = next_random();
            p  = random_pc();
            fn = r[2] ? exu_pkg::ALU_EQ : exu_pkg::ALU_SLT;
            if (r[1:0] == 2'd2) begin
                // jal with junk in the overridden fields
                issue_op("jal", main_word(r[3], r[4], 1'b0, lsu_pkg::MEM_NONE, exu_pkg::PC_JAL,
                         exu_pkg::alu_fn_e'(r[8:6]), exu_pkg::src_sel_e'(r[10:9])),
                         a, b, i, p, next_random(),
                         make_expect(1'b1, p + 32'd4, p + i, 1'b0, 32'd0));
            end else if (r[1:0] == 2'd3) begin
                issue_op("jalr", main_word(r[3], r[4], 1'b0, lsu_pkg::MEM_NONE,
                         exu_pkg::PC_JALR, exu_pkg::alu_fn_e'(r[8:6]),
                         exu_pkg::src_sel_e'(r[10:9])), a, b, i, p, next_random(),
                         make_expect(1'b1, p + 32'd4, (a + i) & 32'hffff_fffe, 1'b0, 32'd0));
            end else begin
                // taken when the compare differs from invert
                res = alu_model(exu_pkg::SRC_RS1_RS2, fn, r[3], a, b, i, p);
                issue_op("branch", main_word(r[3], r[4], 1'b0, lsu_pkg::MEM_NONE,
                         exu_pkg::PC_BRANCH, fn, exu_pkg::SRC_RS1_RS2), a, b, i, p,
                         next_random(), make_expect(1'b1, res,
                         (res[0] != r[4]) ? p + i : p + 32'd4, 1'b0, 32'd0));
            end
            if (r[11])
                go_idle();
        end
    endtask

    task automatic run_memory(int count);
        logic [31:0] r;
        logic [31:0] target;
        for (int n = 0; n < count; n++) begin
            r      = next_random();
            target = next_random();
            if (r[2]) begin
                issue_store(random_size(r[1:0]), target, next_random());
                // load right behind the store, same word
                if (r[3])
                    issue_load(random_size(r[5:4]), r[6], {target[31:2], r[8:7]});
            end else begin
                issue_load(random_size(r[1:0]), r[6], target);
            end
            if (r[9])
                go_idle();
        end
    endtask

    task automatic run_system(int count);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] p;
        logic [31:0] csr;
        for (int n = 0; n < count; n++) begin
            r   = next_random();
            a   = next_random();
            p   = random_pc();
            csr = next_random();
            if (r[0]) begin
                issue_op("mret", sys_word(exu_pkg::SYS_MRET, r[20:7]), a, next_random(),
                         next_random(), p, csr, make_expect(1'b0, 32'd0, csr, 1'b0, 32'd0));
            end else begin
                issue_op("ebreak", sys_word(exu_pkg::SYS_EBREAK, r[20:7]), a, next_random(),
                         next_random(), p, csr, make_expect(1'b0, 32'd0, p + 32'd4, 1'b1, a));
            end
            if (r[1])
                go_idle();
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        seed      = 32'hd55b2b51;
        valid     = 1'b0;
        opt       = '0;
        rs1_d     = '0;
        rs2_d     = '0;
        imm       = '0;
        pc        = '0;
        csr_rdata = '0;

        wait_reset();
        fill_ram();
        run_alu(200);
        run_flow(120);
        run_memory(200);
        // sweep afterwards shows the system words left the RAM alone
        run_system(40);
        sweep_ram();
        go_idle();
        wait_drained();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: exu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module exu_sva (
    input logic             clk,
    input logic             reset,
    input logic             valid,
    input exu_pkg::exu_op_u opt,
    input logic             store_en,
    input logic             ready,
    input logic             halt
);

    // ------------------------------
    // valid and ready pulses
    // ------------------------------

    ready_after_valid: assert property (
        @(posedge clk) disable iff (reset) valid |=> ready
    ) else $error("ready did not follow valid by one cycle");

    ready_only_after_valid: assert property (
        @(posedge clk) disable iff (reset) ready |-> $past(valid)
    ) else $error("ready high without a valid one cycle earlier");

    // stage registers cleared by reset
    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !ready && !halt
    ) else $error("ready or halt high in the cycle after reset");

    // ------------------------------
    // halt and memory side
    // ------------------------------

    halt_needs_ready: assert property (
        @(posedge clk) disable iff (reset) halt |-> ready
    ) else $error("halt high while ready is low");

    no_system_store: assert property (
        @(posedge clk) store_en |-> !opt.main.sys
    ) else $error("RAM write enabled for a system operation");

endmodule

bind exu_top exu_sva exu_sva_inst (
    .clk      (clk),
    .reset    (reset),
    .valid    (valid),
    .opt      (opt),
    .store_en (store_en),
    .ready    (ready),
    .halt     (halt)
);

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 4 rising edges, released like any other input
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: exu_top.sv
`timescale 1ns/100ps
`default_nettype none

module exu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  exu_pkg::exu_op_u    opt,
    input  logic [31:0]         rs1_d,
    input  logic [31:0]         rs2_d,
    input  logic [31:0]         imm,
    input  logic [31:0]         pc,
    input  logic [31:0]         csr_rdata,
    output logic                ready,
    output logic [31:0]         rd_d,
    output logic [31:0]         dnpc,
    output logic                halt,
    output logic [31:0]         exit_code
);
    exu_pkg::src_sel_e  src_sel;
    exu_pkg::alu_fn_e   alu_fn;
    exu_pkg::pc_sel_e   pc_sel;
    lsu_pkg::mem_size_e mem_size;
    lsu_pkg::mem_size_e load_size;
    logic               modifier;
    logic               invert;
    logic               is_mret;
    logic               store_en;
    logic               load_sign;
    logic [1:0]         load_off;
    logic               cmp;
    logic [31:0]        res;
    logic [31:0]        next_pc;
    logic [31:0]        load_data;

    exu_ctrl ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .opt       (opt),
        .next_pc   (next_pc),
        .res       (res),
        .load_data (load_data),
        .rs1_d     (rs1_d),
        .src_sel   (src_sel),
        .alu_fn    (alu_fn),
        .modifier  (modifier),
        .pc_sel    (pc_sel),
        .invert    (invert),
        .is_mret   (is_mret),
        .store_en  (store_en),
        .mem_size  (mem_size),
        .load_size (load_size),
        .load_sign (load_sign),
        .load_off  (load_off),
        .ready     (ready),
        .halt      (halt),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .exit_code (exit_code)
    );

    exu_alu alu_inst (
        .src_sel  (src_sel),
        .alu_fn   (alu_fn),
        .modifier (modifier),
        .rs1_d    (rs1_d),
        .rs2_d    (rs2_d),
        .imm      (imm),
        .pc       (pc),
        .res      (res),
        .cmp      (cmp)
    );

    exu_next_pc next_pc_inst (
        .pc_sel    (pc_sel),
        .invert    (invert),
        .is_mret   (is_mret),
        .cmp       (cmp),
        .pc        (pc),
        .rs1_d     (rs1_d),
        .imm       (imm),
        .csr_rdata (csr_rdata),
        .next_pc   (next_pc)
    );

    // memory address is the ALU sum
    exu_lsu lsu_inst (
        .clk       (clk),
        .store_en  (store_en),
        .mem_size  (mem_size),
        .load_size (load_size),
        .load_sign (load_sign),
        .load_off  (load_off),
        .addr      (res),
        .rs2_d     (rs2_d),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// File: exu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module exu_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        valid,
    input  exu_pkg::exu_op_u            opt,
    input  logic [exu_pkg::XLEN-1:0]    next_pc,
    input  logic [exu_pkg::XLEN-1:0]    res,
    input  logic [exu_pkg::XLEN-1:0]    load_data,
    input  logic [exu_pkg::XLEN-1:0]    rs1_d,
    output exu_pkg::src_sel_e           src_sel,
    output exu_pkg::alu_fn_e            alu_fn,
    output logic                        modifier,
    output exu_pkg::pc_sel_e            pc_sel,
    output logic                        invert,
    output logic                        is_mret,
    output logic                        store_en,
    output lsu_pkg::mem_size_e          mem_size,
    output lsu_pkg::mem_size_e          load_size,
    output logic                        load_sign,
    output logic [1:0]                  load_off,
    output logic                        ready,
    output logic                        halt,
    output logic [exu_pkg::XLEN-1:0]    rd_d,
    output logic [exu_pkg::XLEN-1:0]    dnpc,
    output logic [exu_pkg::XLEN-1:0]    exit_code
);
    exu_pkg::op_main_t            op_main;
    exu_pkg::op_sys_t             op_sys;
    logic                         is_sys;
    logic                         is_ebreak;
    logic                         link;
    logic [exu_pkg::XLEN-1:0]     result_q;

    // ------------------------------
    // decode
    // ------------------------------
    assign op_main = opt.main;
    assign op_sys  = opt.sys;

    assign is_sys    = op_main.sys;
    assign is_ebreak = is_sys && op_sys.sys_fn == exu_pkg::SYS_EBREAK;
    assign is_mret   = is_sys && op_sys.sys_fn == exu_pkg::SYS_MRET;

    // system words never touch memory or redirect by themselves
    assign mem_size = is_sys ? lsu_pkg::MEM_NONE : op_main.mem_size;
    assign pc_sel   = is_sys ? exu_pkg::PC_SEQ : op_main.pc_sel;
    assign store_en = valid && !op_main.load && mem_size != lsu_pkg::MEM_NONE;

    // jal and jalr write back the link address pc + 4
    assign link     = pc_sel == exu_pkg::PC_JAL || pc_sel == exu_pkg::PC_JALR;
    assign src_sel  = link ? exu_pkg::SRC_PC_IMM : op_main.src_sel;
    assign alu_fn   = link ? exu_pkg::ALU_ADD : op_main.alu_fn;
    // load sign shares the modifier bit so memory addresses always add
    assign modifier = (op_main.modifier && mem_size == lsu_pkg::MEM_NONE) || link;
    assign invert   = op_main.invert;

    // ------------------------------
    // stage registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ready     <= 1'b0;
            halt      <= 1'b0;
            load_size <= lsu_pkg::MEM_NONE;
        end else begin
            ready     <= valid;
            halt      <= valid && is_ebreak;
            load_size <= (valid && op_main.load) ? mem_size : lsu_pkg::MEM_NONE;
        end
    end

    // payload only moves with a valid operation
    always_ff @(posedge clk) begin
        if (valid) begin
            dnpc      <= next_pc;
            result_q  <= res;
            exit_code <= rs1_d;
            load_sign <= op_main.modifier;
            load_off  <= res[1:0];
        end
    end

    // load data wins only for a load in flight
    assign rd_d = (load_size != lsu_pkg::MEM_NONE) ? load_data : result_q;

endmodule

`default_nettype wire

// File: exu_next_pc.sv
`timescale 1ns/100ps
`default_nettype none

module exu_next_pc (
    input  exu_pkg::pc_sel_e            pc_sel,
    input  logic                        invert,
    input  logic                        is_mret,
    input  logic                        cmp,
    input  logic [exu_pkg::XLEN-1:0]    pc,
    input  logic [exu_pkg::XLEN-1:0]    rs1_d,
    input  logic [exu_pkg::XLEN-1:0]    imm,
    input  logic [exu_pkg::XLEN-1:0]    csr_rdata,
    output logic [exu_pkg::XLEN-1:0]    next_pc
);
    logic                     taken;
    logic                     jump;
    logic [exu_pkg::XLEN-1:0] base;
    logic [exu_pkg::XLEN-1:0] offset;
    logic [exu_pkg::XLEN-1:0] target;

    assign taken = pc_sel == exu_pkg::PC_BRANCH && (cmp != invert);
    assign jump  = pc_sel == exu_pkg::PC_JAL || pc_sel == exu_pkg::PC_JALR;

    // single adder, operands picked by kind
    assign base   = (pc_sel == exu_pkg::PC_JALR) ? rs1_d : pc;
    assign offset = (taken || jump) ? imm : 32'd4;
    assign target = base + offset;

    always_comb begin
        next_pc = target;
        if (pc_sel == exu_pkg::PC_JALR)
            next_pc[0] = 1'b0;
        if (is_mret)
            next_pc = csr_rdata;
    end

endmodule

`default_nettype wire

// File: exu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
    input  exu_pkg::src_sel_e           src_sel,
    input  exu_pkg::alu_fn_e            alu_fn,
    input  logic                        modifier,
    input  logic [exu_pkg::XLEN-1:0]    rs1_d,
    input  logic [exu_pkg::XLEN-1:0]    rs2_d,
    input  logic [exu_pkg::XLEN-1:0]    imm,
    input  logic [exu_pkg::XLEN-1:0]    pc,
    output logic [exu_pkg::XLEN-1:0]    res,
    output logic                        cmp
);
    logic [exu_pkg::XLEN-1:0] a;
    logic [exu_pkg::XLEN-1:0] b;
    logic                     link;
    logic                     lt;
    logic                     eq;
    logic [4:0]               shamt;

    // modifier on the pc pairing selects the link constant
    assign link = modifier && src_sel == exu_pkg::SRC_PC_IMM;

    always_comb begin
        case (src_sel)
            exu_pkg::SRC_IMM_ZERO: {a, b} = {imm, 32'd0};
            exu_pkg::SRC_PC_IMM:   {a, b} = {pc, link ? 32'd4 : imm};
            exu_pkg::SRC_RS1_RS2:  {a, b} = {rs1_d, rs2_d};
            default:               {a, b} = {rs1_d, imm};
        endcase
    end

    assign shamt = b[4:0];
    assign eq    = a == b;
    assign lt    = modifier ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (alu_fn)
            exu_pkg::ALU_ADD: res = (modifier && !link) ? a - b : a + b;
            exu_pkg::ALU_SLL: res = a << shamt;
            exu_pkg::ALU_SLT: res = {31'd0, lt};
            exu_pkg::ALU_XOR: res = a ^ b;
            // sra when modifier is set
            exu_pkg::ALU_SRL: res = modifier ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            exu_pkg::ALU_OR:  res = a | b;
            exu_pkg::ALU_AND: res = a & b;
            default:          res = {31'd0, eq};
        endcase
    end

    // branch condition before inversion
    assign cmp = (alu_fn == exu_pkg::ALU_EQ) ? eq : lt;

endmodule

`default_nettype wire

// File: exu_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module exu_lsu (
    input  logic                clk,
    input  logic                store_en,
    input  lsu_pkg::mem_size_e  mem_size,
    input  lsu_pkg::mem_size_e  load_size,
    input  logic                load_sign,
    input  logic [1:0]          load_off,
    input  logic [31:0]         addr,
    input  logic [31:0]         rs2_d,
    output logic [31:0]         load_data
);
    lsu_pkg::store_req_t req;
    logic [1:0]          st_lane;
    logic [1:0]          ld_lane;
    logic [3:0]          base_mask;
    logic [31:0]         rdata;
    logic [31:0]         shifted;

    // byte lane of the access, misaligned low bits dropped
    function automatic logic [1:0] lane_of(lsu_pkg::mem_size_e size, logic [1:0] low);
        case (size)
            lsu_pkg::MEM_BYTE: lane_of = low;
            lsu_pkg::MEM_HALF: lane_of = {low[1], 1'b0};
            default:           lane_of = 2'd0;
        endcase
    endfunction

    // ------------------------------
    // store side
    // ------------------------------
    assign st_lane = lane_of(mem_size, addr[1:0]);

    always_comb begin
        case (mem_size)
            lsu_pkg::MEM_BYTE: base_mask = 4'b0001;
            lsu_pkg::MEM_HALF: base_mask = 4'b0011;
            lsu_pkg::MEM_WORD: base_mask = 4'b1111;
            default:           base_mask = 4'b0000;
        endcase
    end

    assign req.addr = addr[lsu_pkg::RAM_AW+1:2];
    assign req.data = rs2_d << {st_lane, 3'b000};
    assign req.mask = base_mask << st_lane;

    data_ram ram_inst (
        .clk   (clk),
        .req   (req),
        .write (store_en),
        .raddr (addr[lsu_pkg::RAM_AW+1:2]),
        .rdata (rdata)
    );

    // ------------------------------
    // load side, one cycle later
    // ------------------------------
    assign ld_lane = lane_of(load_size, load_off);
    assign shifted = rdata >> {ld_lane, 3'b000};

    always_comb begin
        case (load_size)
            lsu_pkg::MEM_BYTE: load_data = {{24{load_sign & shifted[7]}}, shifted[7:0]};
            lsu_pkg::MEM_HALF: load_data = {{16{load_sign & shifted[15]}}, shifted[15:0]};
            lsu_pkg::MEM_WORD: load_data = shifted;
            default:           load_data = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  logic                        clk,
    input  lsu_pkg::store_req_t         req,
    input  logic                        write,
    input  logic [lsu_pkg::RAM_AW-1:0]  raddr,
    output logic [31:0]                 rdata
);
    logic [31:0] mem [lsu_pkg::RAM_WORDS];

    // per-byte write enables
    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.mask[i])
                    mem[req.addr][8*i +: 8] <= req.data[8*i +: 8];
            end
        end
    end

    // registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: exu_pkg.sv
`default_nettype none

package exu_pkg;

    localparam int XLEN = 32;

    // ------------------------------
    // control codes
    // ------------------------------

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SLL = 3'd1,
        ALU_SLT = 3'd2,
        ALU_XOR = 3'd3,
        ALU_SRL = 3'd4,
        ALU_OR  = 3'd5,
        ALU_AND = 3'd6,
        ALU_EQ  = 3'd7
    } alu_fn_e;

    // operand pairings, first operand named first
    typedef enum logic [1:0] {
        SRC_IMM_ZERO = 2'd0,
        SRC_PC_IMM   = 2'd1,
        SRC_RS1_RS2  = 2'd2,
        SRC_RS1_IMM  = 2'd3
    } src_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2,
        PC_JALR   = 2'd3
    } pc_sel_e;

    typedef enum logic {
        SYS_EBREAK = 1'b0,
        SYS_MRET   = 1'b1
    } sys_fn_e;

    // ------------------------------
    // operation word views
    // ------------------------------

    // modifier means sub, sra or signed depending on the function
    typedef struct packed {
        logic               sys;
        logic               modifier;
        logic               invert;
        logic               load;
        lsu_pkg::mem_size_e mem_size;
        pc_sel_e            pc_sel;
        alu_fn_e            alu_fn;
        src_sel_e           src_sel;
        logic [2:0]         spare;
    } op_main_t;

    typedef struct packed {
        logic        sys;
        sys_fn_e     sys_fn;
        logic [13:0] spare;
    } op_sys_t;

    // sys flag is bit 15 in both views
    typedef union packed {
        op_main_t main;
        op_sys_t  sys;
    } exu_op_u;

endpackage

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ------------------------------
    // access sizes
    // ------------------------------

    // none means no memory access at all
    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_BYTE = 2'd1,
        MEM_HALF = 2'd2,
        MEM_WORD = 2'd3
    } mem_size_e;

    // ------------------------------
    // local data RAM
    // ------------------------------

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    // one store as seen by the RAM, data already on its byte lanes
    typedef struct packed {
        logic [RAM_AW-1:0] addr;
        logic [31:0]       data;
        logic [3:0]        mask;
    } store_req_t;

endpackage

`default_nettype wire
